// File: logic/trojan_bench_pkg.sv
// Shared widths, seed and tap positions for the trigger LFSR and the trojan event counter
package trojan_bench_pkg;

    // Trigger LFSR
    localparam int unsigned LFSR_WIDTH = 128;

    localparam logic [LFSR_WIDTH-1:0] LFSR_INIT_DEFAULT =
        128'hFEDCBA9876543210FEDCBA9876543210;

    // Fibonacci feedback taps, XORed into bit 0 on each step
    localparam int unsigned LFSR_TAP_0 = 127;
    localparam int unsigned LFSR_TAP_1 = 6;
    localparam int unsigned LFSR_TAP_2 = 1;
    localparam int unsigned LFSR_TAP_3 = 0;

    // Rare-event counter inside the trojan
    localparam int unsigned TRIG_CNT_WIDTH = 8;

    // Events needed before the trigger fires
    localparam logic [TRIG_CNT_WIDTH-1:0] TRIGGER_THRESHOLD_DEFAULT = 8'd4;

endpackage : trojan_bench_pkg

// File: logic/decoder_pkg.sv
// Data widths and the FSM state type for the one-hot decoder and the program address counter
package decoder_pkg;

    // Encoded code in, one-hot word out
    localparam int unsigned CODE_WIDTH    = 8;
    localparam int unsigned DECODED_WIDTH = 16;

    // Program address, wraps at 2^13
    localparam int unsigned ADDR_WIDTH = 13;

    // Four-step decode cycle
    typedef enum logic [1:0] {
        DEC_IDLE  = 2'd0,  // Clear the word
        DEC_SET   = 2'd1,  // Sample the code, set one bit
        DEC_READY = 2'd2,  // Raise valid
        DEC_HOLD  = 2'd3   // Drop valid, back to idle
    } decode_state_e;

endpackage : decoder_pkg

// File: logic/rare_event_lfsr.sv
// 128-bit Fibonacci LFSR stepped on enable; flags the rare state whose four low bits are all ones
`timescale 1ns/1ps

module rare_event_lfsr import trojan_bench_pkg::*; #(
    parameter logic [LFSR_WIDTH-1:0] LFSR_INIT = LFSR_INIT_DEFAULT
) (
    input  logic clk,
    input  logic pon_rst_i,
    input  logic step_i,        // Advance one position
    output logic rare_event_o
);

    logic [LFSR_WIDTH-1:0] lfsr_q;
    logic                  feedback;

    assign feedback = lfsr_q[LFSR_TAP_0] ^ lfsr_q[LFSR_TAP_1] ^
                      lfsr_q[LFSR_TAP_2] ^ lfsr_q[LFSR_TAP_3];

    always_ff @(posedge clk or posedge pon_rst_i) begin
        if (pon_rst_i) begin
            lfsr_q <= LFSR_INIT;
        end else if (step_i) begin
            lfsr_q <= {lfsr_q[LFSR_WIDTH-2:0], feedback};  // Shift left, feedback at bit 0
        end
    end

    // Roughly one state in sixteen
    assign rare_event_o = &lfsr_q[3:0];

endmodule : rare_event_lfsr

// File: logic/trojan1_trigger.sv
// Trojan trigger: counts qualified rare events and fires a one-cycle registered pulse at the threshold
`timescale 1ns/1ps

module trojan1_trigger import trojan_bench_pkg::*; #(
    parameter logic [TRIG_CNT_WIDTH-1:0] TRIGGER_THRESHOLD = TRIGGER_THRESHOLD_DEFAULT
) (
    input  logic clk,
    input  logic pon_rst_i,
    input  logic r1_i,         // Rare event from the LFSR
    input  logic count_en_i,   // Only enabled cycles count
    output logic trigger_o
);

    logic [TRIG_CNT_WIDTH-1:0] event_cnt_q;
    logic [TRIG_CNT_WIDTH-1:0] event_cnt_inc;
    logic                      event_seen;
    logic                      threshold_hit;

    assign event_seen    = r1_i & count_en_i;
    assign event_cnt_inc = event_cnt_q + 1'b1;

    // This event completes the set
    assign threshold_hit = event_seen && (event_cnt_inc == TRIGGER_THRESHOLD);

    always_ff @(posedge clk or posedge pon_rst_i) begin
        if (pon_rst_i) begin
            event_cnt_q <= '0;
        end else if (threshold_hit) begin
            event_cnt_q <= '0;  // Restart so it can fire again
        end else if (event_seen) begin
            event_cnt_q <= event_cnt_inc;
        end
    end

    // Pulse lasts exactly one cycle
    always_ff @(posedge clk or posedge pon_rst_i) begin
        if (pon_rst_i) begin
            trigger_o <= 1'b0;
        end else begin
            trigger_o <= threshold_hit;
        end
    end

endmodule : trojan1_trigger

// File: logic/onehot_decode_fsm.sv
// Four-state decoder turning an in-range code into a one-hot word, with a one-cycle valid pulse
`timescale 1ns/1ps

module onehot_decode_fsm import decoder_pkg::*; (
    input  logic                     clk,
    input  logic                     pon_rst_i,
    input  logic                     enable_i,
    input  logic                     clear_i,     // Synchronous, wins over enable
    input  logic [CODE_WIDTH-1:0]    code_i,
    output logic [DECODED_WIDTH-1:0] decoded_o,
    output logic                     valid_o
);

    localparam int unsigned SEL_WIDTH = $clog2(DECODED_WIDTH);

    decode_state_e state_q;
    logic          code_in_range;

    assign code_in_range = (code_i < DECODED_WIDTH);

    always_ff @(posedge clk or posedge pon_rst_i) begin
        if (pon_rst_i) begin
            state_q   <= DEC_IDLE;
            decoded_o <= '0;
            valid_o   <= 1'b0;
        end else if (clear_i) begin
            // Trigger wipes the whole decode
            state_q   <= DEC_IDLE;
            decoded_o <= '0;
            valid_o   <= 1'b0;
        end else if (enable_i) begin
            valid_o <= 1'b0;  // Only DEC_READY raises it
            case (state_q)
                DEC_IDLE: begin
                    decoded_o <= '0;
                    state_q   <= DEC_SET;
                end
                DEC_SET: begin
                    // Out-of-range codes leave the word empty
                    if (code_in_range) begin
                        decoded_o[code_i[SEL_WIDTH-1:0]] <= 1'b1;
                    end
                    state_q <= DEC_READY;
                end
                DEC_READY: begin
                    valid_o <= 1'b1;
                    state_q <= DEC_HOLD;
                end
                DEC_HOLD: begin
                    state_q <= DEC_IDLE;
                end
                default: begin
                    state_q <= DEC_IDLE;
                end
            endcase
        end else begin
            valid_o <= 1'b0;  // Gap freezes state, valid never stretches
        end
    end

endmodule : onehot_decode_fsm

// File: logic/prog_addr_counter.sv
// Program address counter: counts enabled cycles and presents the count one cycle later
`timescale 1ns/1ps

module prog_addr_counter import decoder_pkg::*; (
    input  logic                  clk,
    input  logic                  pon_rst_i,
    input  logic                  enable_i,
    input  logic                  clear_i,     // Trigger clear, priority over enable
    output logic [ADDR_WIDTH-1:0] prog_adr_o
);

    logic [ADDR_WIDTH-1:0] addr_cnt_q;

    // Wraps naturally at 2^ADDR_WIDTH
    always_ff @(posedge clk or posedge pon_rst_i) begin
        if (pon_rst_i) begin
            addr_cnt_q <= '0;
        end else if (clear_i) begin
            addr_cnt_q <= '0;
        end else if (enable_i) begin
            addr_cnt_q <= addr_cnt_q + 1'b1;
        end
    end

    // Output copy, updated every cycle regardless of enable
    always_ff @(posedge clk or posedge pon_rst_i) begin
        if (pon_rst_i) begin
            prog_adr_o <= '0;
        end else if (clear_i) begin
            prog_adr_o <= '0;
        end else begin
            prog_adr_o <= addr_cnt_q;
        end
    end

endmodule : prog_addr_counter

// File: logic/trojan1_decoder0_host.sv
// Host top level: decoder and address counter with the LFSR-driven trojan trigger wired in
`timescale 1ns/1ps

module trojan1_decoder0_host
    import trojan_bench_pkg::*;
    import decoder_pkg::*;
#(
    parameter logic [LFSR_WIDTH-1:0]     LFSR_INIT         = LFSR_INIT_DEFAULT,
    parameter logic [TRIG_CNT_WIDTH-1:0] TRIGGER_THRESHOLD = TRIGGER_THRESHOLD_DEFAULT
) (
    input  logic                     clk,
    input  logic                     pon_rst_i,
    input  logic [CODE_WIDTH-1:0]    encoded_input_i,
    input  logic                     decode_enable_i,   // One design step per high cycle
    output logic [DECODED_WIDTH-1:0] decoded_output_o,
    output logic                     decode_valid_o,
    output logic [ADDR_WIDTH-1:0]    prog_adr_o
);

    logic rare_event;
    logic trojan_trigger;

    // Rare-event source, steps with the design
    rare_event_lfsr #(
        .LFSR_INIT (LFSR_INIT)
    ) i_lfsr (
        .clk          (clk),
        .pon_rst_i    (pon_rst_i),
        .step_i       (decode_enable_i),
        .rare_event_o (rare_event)
    );

    trojan1_trigger #(
        .TRIGGER_THRESHOLD (TRIGGER_THRESHOLD)
    ) i_trojan (
        .clk        (clk),
        .pon_rst_i  (pon_rst_i),
        .r1_i       (rare_event),
        .count_en_i (decode_enable_i),  // Events only count while the LFSR moves
        .trigger_o  (trojan_trigger)
    );

    // Payload targets, both cleared by the trigger
    onehot_decode_fsm i_decoder (
        .clk       (clk),
        .pon_rst_i (pon_rst_i),
        .enable_i  (decode_enable_i),
        .clear_i   (trojan_trigger),
        .code_i    (encoded_input_i),
        .decoded_o (decoded_output_o),
        .valid_o   (decode_valid_o)
    );

    prog_addr_counter i_addr_cnt (
        .clk        (clk),
        .pon_rst_i  (pon_rst_i),
        .enable_i   (decode_enable_i),
        .clear_i    (trojan_trigger),
        .prog_adr_o (prog_adr_o)
    );

endmodule : trojan1_decoder0_host

// File: tb/tb_decoder_host.sv
// Simulation top that drives the decoder host through directed tests and predicts its outputs
`timescale 1ns/1ps

module tb_decoder_host import trojan_bench_pkg::*; import decoder_pkg::*; ;

    localparam int unsigned TRIGGER_THRESHOLD = 4;
    localparam int unsigned RESET_CYCLES      = 8;
    localparam int unsigned ALIGN_TIMEOUT     = 8;
    localparam int unsigned TRIGGER_TIMEOUT   = 2000;
    localparam logic [31:0] RNG_SEED          = 32'h928f7d38;
    localparam logic [31:0] RNG_POLY          = 32'h80200003;  // Taps 32, 22, 2, 1

    logic                     clk;
    logic                     pon_rst_i;
    logic [CODE_WIDTH-1:0]    encoded_input_i;
    logic                     decode_enable_i;
    logic [DECODED_WIDTH-1:0] decoded_output_o;
    logic                     decode_valid_o;
    logic [ADDR_WIDTH-1:0]    prog_adr_o;

    // Reference model state
    logic [LFSR_WIDTH-1:0]    lfsr_m;
    int unsigned              evt_cnt_m;
    logic                     trig_m;       // Trigger register as seen by the DUT
    decode_state_e            state_m;
    logic [DECODED_WIDTH-1:0] word_m;
    logic                     valid_m;
    logic [ADDR_WIDTH-1:0]    cnt_m;
    logic [ADDR_WIDTH-1:0]    adr_m;
    logic                     clear_seen;   // Set whenever the model applies a trigger clear

    logic [31:0] rng_state;

    trojan1_decoder0_host #(
        .LFSR_INIT         (LFSR_INIT_DEFAULT),
        .TRIGGER_THRESHOLD (TRIGGER_THRESHOLD)
    ) i_dut (
        .clk              (clk),
        .pon_rst_i        (pon_rst_i),
        .encoded_input_i  (encoded_input_i),
        .decode_enable_i  (decode_enable_i),
        .decoded_output_o (decoded_output_o),
        .decode_valid_o   (decode_valid_o),
        .prog_adr_o       (prog_adr_o)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;  // 10 ns period

    // Galois LFSR stepped once per random bit
    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] value;
        logic        lsb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lsb       = rng_state[0];
            rng_state = rng_state >> 1;
            if (lsb) rng_state = rng_state ^ RNG_POLY;
            value = {value[30:0], lsb};
        end
        return value;
    endfunction

    function automatic logic [DECODED_WIDTH-1:0] onehot_for(input logic [CODE_WIDTH-1:0] code);
        logic [DECODED_WIDTH-1:0] word;
        word = '0;
        if (code < DECODED_WIDTH) word[code[3:0]] = 1'b1;
        return word;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED: %s got 0x%0h expected 0x%0h at %0t",
                     name, actual, expected, $time);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s at %0t", what, $time);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic expect_all_outputs_zero();
        check_value("decoded_output_o", decoded_output_o, '0);
        check_value("decode_valid_o", decode_valid_o, '0);
        check_value("prog_adr_o", prog_adr_o, '0);
    endtask

    task automatic reset_model();
        lfsr_m     = LFSR_INIT_DEFAULT;
        evt_cnt_m  = 0;
        trig_m     = 1'b0;
        state_m    = DEC_IDLE;
        word_m     = '0;
        valid_m    = 1'b0;
        cnt_m      = '0;
        adr_m      = '0;
        clear_seen = 1'b0;
    endtask

    // Advance the model by one clock edge with the inputs that were applied
    task automatic update_model(input logic en, input logic [CODE_WIDTH-1:0] code);
        logic rare;
        logic hit;
        logic fb;
        rare = &lfsr_m[3:0];
        hit  = en && rare && (evt_cnt_m + 1 == TRIGGER_THRESHOLD);
        if (trig_m) begin
            state_m    = DEC_IDLE;  // Payload wipes decoder and address
            word_m     = '0;
            valid_m    = 1'b0;
            cnt_m      = '0;
            adr_m      = '0;
            clear_seen = 1'b1;
        end else begin
            adr_m   = cnt_m;        // Output lags the count
            valid_m = 1'b0;
            if (en) begin
                cnt_m = cnt_m + 1'b1;
                case (state_m)
                    DEC_IDLE: begin
                        word_m  = '0;
                        state_m = DEC_SET;
                    end
                    DEC_SET: begin
                        word_m  = onehot_for(code);
                        state_m = DEC_READY;
                    end
                    DEC_READY: begin
                        valid_m = 1'b1;
                        state_m = DEC_HOLD;
                    end
                    default: begin
                        state_m = DEC_IDLE;
                    end
                endcase
            end
        end
        if (en) begin
            fb     = lfsr_m[LFSR_TAP_0] ^ lfsr_m[LFSR_TAP_1] ^
                     lfsr_m[LFSR_TAP_2] ^ lfsr_m[LFSR_TAP_3];
            lfsr_m = {lfsr_m[LFSR_WIDTH-2:0], fb};
        end
        if (hit) evt_cnt_m = 0;
        else if (en && rare) evt_cnt_m++;
        trig_m = hit;
    endtask

    // Drive 1 ns after an edge, clock once and compare with the model
    task automatic run_cycle(input logic en, input logic [CODE_WIDTH-1:0] code);
        decode_enable_i = en;
        encoded_input_i = code;
        @(posedge clk);
        update_model(en, code);
        #1;
        check_value("decoded_output_o", decoded_output_o, word_m);
        check_value("decode_valid_o", decode_valid_o, valid_m);
        check_value("prog_adr_o", prog_adr_o, adr_m);
    endtask

    task automatic align_to_idle();
        int unsigned guard;
        guard = 0;
        while (state_m != DEC_IDLE || trig_m) begin
            if (guard == ALIGN_TIMEOUT) report_timeout("decoder to return to idle");
            run_cycle(1'b1, rand_bits(CODE_WIDTH));
            guard++;
        end
    endtask

    // One full decode of four enabled edges with optional disabled gaps
    task automatic decode_cycle(input logic [CODE_WIDTH-1:0] code, input bit with_gaps);
        int unsigned gap;
        align_to_idle();
        clear_seen = 1'b0;
        for (int edge_no = 1; edge_no <= 4; edge_no++) begin
            gap = with_gaps ? rand_bits(2) : 0;
            repeat (gap) begin
                run_cycle(1'b0, code);
                if (!clear_seen) check_value("decode_valid_o in gap", decode_valid_o, '0);
            end
            run_cycle(1'b1, code);
            if (!clear_seen && edge_no == 3) begin
                check_value("decode_valid_o", decode_valid_o, 1'b1);
                check_value("decoded_output_o", decoded_output_o, onehot_for(code));
            end
            if (!clear_seen && edge_no == 4) begin
                check_value("decode_valid_o", decode_valid_o, '0);
            end
        end
    endtask

    // Hold enable until the model predicts the trigger and check the payload
    task automatic fire_and_check_trigger();
        int unsigned guard;
        guard = 0;
        while (!trig_m) begin
            if (guard == TRIGGER_TIMEOUT) report_timeout("trojan trigger");
            run_cycle(1'b1, rand_bits(4));
            guard++;
        end
        run_cycle(1'b1, rand_bits(4));  // Clear edge
        expect_all_outputs_zero();
        run_cycle(1'b1, rand_bits(4));
        check_value("prog_adr_o after clear", prog_adr_o, 13'd0);
        run_cycle(1'b1, rand_bits(4));
        check_value("prog_adr_o after clear", prog_adr_o, 13'd1);  // Count restarted
    endtask

    task automatic apply_reset();
        pon_rst_i = 1'b1;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
            expect_all_outputs_zero();
        end
        pon_rst_i = 1'b0;
        reset_model();
        expect_all_outputs_zero();
        repeat (2) run_cycle(1'b0, '0);
    endtask

    task automatic in_range_decodes();
        repeat (12) decode_cycle(rand_bits(4), 1'b0);
    endtask

    task automatic out_of_range_decodes();
        repeat (8) decode_cycle(8'd16 + rand_bits(8) % 240, 1'b0);
    endtask

    task automatic gapped_decodes();
        repeat (10) decode_cycle(rand_bits(4), 1'b1);
    endtask

    task automatic recover_after_trigger();
        decode_cycle(rand_bits(4), 1'b0);
        fire_and_check_trigger();
        decode_cycle(rand_bits(4), 1'b1);
    endtask

    initial begin
        pon_rst_i       = 1'b0;
        decode_enable_i = 1'b0;
        encoded_input_i = '0;
        rng_state       = RNG_SEED;
        reset_model();
        #2;
        apply_reset();
        in_range_decodes();
        out_of_range_decodes();
        gapped_decodes();
        fire_and_check_trigger();
        recover_after_trigger();
        $display("TEST PASS");
        $finish;
    end

endmodule : tb_decoder_host

// File: sources.f
logic/trojan_bench_pkg.sv
logic/decoder_pkg.sv
logic/rare_event_lfsr.sv
logic/trojan1_trigger.sv
logic/onehot_decode_fsm.sv
logic/prog_addr_counter.sv
logic/trojan1_decoder0_host.sv
tb/tb_decoder_host.sv
